/* matmul.f */
+incdir+src
src/matmul_pkg.sv
src/step_if.sv
src/mm_ctrl.sv
src/dot_lanes.sv
src/e_buffer.sv
src/result_acc.sv
src/matmul_top.sv
bench/matmul_tb.sv

/* Bender.yml */
package:
  name: matmul

sources:
  - include_dirs:
      - src
    files:
      - src/matmul_pkg.sv
      - src/step_if.sv
      - src/mm_ctrl.sv
      - src/dot_lanes.sv
      - src/e_buffer.sv
      - src/result_acc.sv
      - src/matmul_top.sv
  - target: test
    include_dirs:
      - src
    files:
      - bench/matmul_tb.sv

/* bench/matmul_tb.sv */
// self-checking testbench for the matrix engine, compile with the file list and run matmul_tb
`timescale 1ns/1ns
`default_nettype none

`include "matmul_cfg.svh"

module matmul_tb
    import matmul_pkg::*;
();

    localparam int A_WORDS    = `MM_A_ROWS * WORDS_PER_DOT;
    localparam int B_WORDS    = `MM_B_COLS * WORDS_PER_DOT;
    // start edge, one tag per word, drain and done
    localparam int RUN_CYCLES = 1 + WORDS_PER_DOT * C_ELEMS + PIPE_DEPTH + 1;
    localparam int DONE_LIMIT = 100;
    localparam int POKE_CYCLE = 10;
    localparam int QUIET_WAIT = 10;

    logic    i_clk = 1'b0;
    logic    i_rst_n;
    logic    i_start;
    logic    o_busy;
    logic    o_done;
    a_addr_t o_a_addr;
    word_t   i_a_word;
    b_addr_t o_b_addr;
    word_t   i_b_word;
    logic    i_e_wen;
    c_idx_t  i_e_idx;
    elem_t   i_e_data;
    logic    i_c_en;
    c_idx_t  i_c_idx;
    elem_t   o_c;

    elem_t       a_m   [`MM_A_ROWS][`MM_INNER];
    elem_t       b_m   [`MM_INNER][`MM_B_COLS];
    elem_t       e_m   [C_ELEMS];
    elem_t       c_exp [C_ELEMS];
    word_t       a_mem [A_WORDS];
    word_t       b_mem [B_WORDS];
    logic [31:0] lfsr;

    int     errors      = 0;
    int     timeouts    = 0;
    int     runs        = 0;
    int     reads       = 0;
    int     done_pulses = 0;
    logic   quiet_chk   = 1'b0;
    logic   rd_pend     = 1'b0;
    c_idx_t rd_idx_q;

    matmul_top matmul_top_i (
        .i_clk    (i_clk),
        .i_rst_n  (i_rst_n),
        .i_start  (i_start),
        .o_busy   (o_busy),
        .o_done   (o_done),
        .o_a_addr (o_a_addr),
        .i_a_word (i_a_word),
        .o_b_addr (o_b_addr),
        .i_b_word (i_b_word),
        .i_e_wen  (i_e_wen),
        .i_e_idx  (i_e_idx),
        .i_e_data (i_e_data),
        .i_c_en   (i_c_en),
        .i_c_idx  (i_c_idx),
        .o_c      (o_c)
    );

    always #50 i_clk = ~i_clk;

    // operand memories, one cycle read latency
    always @(posedge i_clk) begin
        i_a_word <= a_mem[o_a_addr];
        i_b_word <= b_mem[o_b_addr];
    end

    // quiet from the first reset edge until the first start
    always @(posedge i_clk) begin
        if (!i_rst_n) begin
            quiet_chk <= 1'b1;
        end else if (i_start) begin
            quiet_chk <= 1'b0;
        end
        rd_pend  <= i_c_en;
        rd_idx_q <= i_c_idx;
    end

    always @(negedge i_clk) begin
        if (o_done === 1'b1) begin
            done_pulses++;
        end
    end

    // ====================
    // assertions
    // ====================
    a_quiet_in_reset: assert property (@(posedge i_clk) quiet_chk |-> !o_busy && !o_done)
        else begin
            errors++;
            $display("Fail %0t o_busy/o_done expected 0/0 got %b/%b", $time,
                     $sampled(o_busy), $sampled(o_done));
        end

    a_busy_on_start: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_start && !o_busy && !o_done |=> o_busy)
        else begin
            errors++;
            $display("Fail %0t o_busy expected 1 got %b", $time, $sampled(o_busy));
        end

    a_done_one_cycle: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_done |=> !o_done)
        else begin
            errors++;
            $display("Fail %0t o_done expected 0 got %b", $time, $sampled(o_done));
        end

    // busy drops in the same cycle as done
    a_busy_falls_with_done: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        $rose(o_done) |-> !o_busy && $past(o_busy))
        else begin
            errors++;
            $display("Fail %0t o_busy expected 0 got %b", $time, $sampled(o_busy));
        end

    a_c_readback: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        rd_pend |-> o_c == c_exp[rd_idx_q])
        else begin
            errors++;
            $display("Fail %0t o_c expected %h got %h", $time,
                     c_exp[$sampled(rd_idx_q)], $sampled(o_c));
        end

    // ====================
    // stimulus helpers
    // ====================
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;
        end
        return s >> 1;
    endfunction

    function automatic elem_t rand_elem();
        elem_t r;
        r = '0;
        for (int i = 0; i < `MM_ELEM_W; i++) begin
            lfsr = lfsr_next(lfsr);
            r = {r[`MM_ELEM_W-2:0], lfsr[0]};
        end
        return r;
    endfunction

    // fills A, B and E, packs the operand words and works out C
    task automatic make_operands(input bit saturate);
        elem_t acc;
        for (int r = 0; r < `MM_A_ROWS; r++) begin
            for (int k = 0; k < `MM_INNER; k++) begin
                a_m[r][k] = saturate && r == 0 ? 16'hffff : rand_elem();
            end
        end
        for (int k = 0; k < `MM_INNER; k++) begin
            for (int c = 0; c < `MM_B_COLS; c++) begin
                b_m[k][c] = saturate && c == 0 ? 16'hffff : rand_elem();
            end
        end
        for (int i = 0; i < C_ELEMS; i++) begin
            e_m[i] = rand_elem();
        end
        // A words along a row, B words down a column
        for (int w = 0; w < WORDS_PER_DOT; w++) begin
            for (int l = 0; l < `MM_LANES; l++) begin
                for (int r = 0; r < `MM_A_ROWS; r++) begin
                    a_mem[r*WORDS_PER_DOT + w][l] = a_m[r][w*`MM_LANES + l];
                end
                for (int c = 0; c < `MM_B_COLS; c++) begin
                    b_mem[c*WORDS_PER_DOT + w][l] = b_m[w*`MM_LANES + l][c];
                end
            end
        end
        for (int r = 0; r < `MM_A_ROWS; r++) begin
            for (int c = 0; c < `MM_B_COLS; c++) begin
                acc = e_m[r*`MM_B_COLS + c];
                for (int k = 0; k < `MM_INNER; k++) begin
                    acc = acc + a_m[r][k] * b_m[k][c];
                end
                c_exp[r*`MM_B_COLS + c] = acc;
            end
        end
    endtask

    task automatic load_e();
        if (timeouts != 0) begin
            return;
        end
        for (int k = 0; k < C_ELEMS; k++) begin
            @(negedge i_clk);
            i_e_wen  = 1'b1;
            i_e_idx  = c_idx_t'(k);
            i_e_data = e_m[k];
        end
        @(negedge i_clk);
        i_e_wen = 1'b0;
    endtask

    task automatic run_engine(input bit poke_while_busy);
        int n;
        int pulses_before;
        if (timeouts != 0) begin
            return;
        end
        pulses_before = done_pulses;
        @(negedge i_clk);
        i_start = 1'b1;
        @(negedge i_clk);
        i_start = 1'b0;
        n = 1;
        while (timeouts == 0 && o_done !== 1'b1) begin
            if (n >= DONE_LIMIT) begin
                timeouts++;
                $display("Timeout at %0t: o_done did not rise within %0d cycles of i_start",
                         $time, DONE_LIMIT);
            end else begin
                @(negedge i_clk);
                n++;
                i_start = poke_while_busy && n == POKE_CYCLE;
            end
        end
        if (timeouts == 0) begin
            runs++;
            assert (n == RUN_CYCLES) else begin
                errors++;
                $display("Fail %0t o_done latency expected %0d got %0d", $time, RUN_CYCLES, n);
            end
            // no second run may follow
            for (int i = 0; i < QUIET_WAIT; i++) begin
                @(negedge i_clk);
            end
            assert (done_pulses == pulses_before + 1) else begin
                errors++;
                $display("Fail %0t o_done pulses expected %0d got %0d", $time,
                         pulses_before + 1, done_pulses);
            end
            assert (o_busy === 1'b0) else begin
                errors++;
                $display("Fail %0t o_busy expected 0 got %b", $time, o_busy);
            end
        end
    endtask

    task automatic read_results();
        if (timeouts != 0) begin
            return;
        end
        for (int k = 0; k < C_ELEMS; k++) begin
            @(negedge i_clk);
            i_c_en  = 1'b1;
            i_c_idx = c_idx_t'(k);
            reads++;
        end
        @(negedge i_clk);
        i_c_en = 1'b0;
        // let the last readback check fire
        @(negedge i_clk);
    endtask

    // ====================
    // main sequence
    // ====================
    initial begin
        i_rst_n  = 1'b0;
        i_start  = 1'b0;
        i_a_word = '0;
        i_b_word = '0;
        i_e_wen  = 1'b0;
        i_e_idx  = '0;
        i_e_data = '0;
        i_c_en   = 1'b0;
        i_c_idx  = '0;
        lfsr     = 32'h201b;
        make_operands(1'b0);
        for (int i = 0; i < 16; i++) begin
            @(negedge i_clk);
        end
        i_rst_n = 1'b1;

        load_e();
        run_engine(1'b0);
        read_results();

        // new operands and E, saturated row and column for overflow
        make_operands(1'b1);
        load_e();
        run_engine(1'b1);
        read_results();

        $display("runs %0d, reads %0d, errors %0d, timeouts %0d", runs, reads, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* src/matmul_top.sv */
// top level of the matrix engine, plain ports for operand memories, E load, C readout and control
`timescale 1ns/1ns
`default_nettype none

module matmul_top
    import matmul_pkg::*;
(
    input  wire logic    i_clk,
    input  wire logic    i_rst_n,
    input  wire logic    i_start,
    output logic         o_busy,
    output logic         o_done,
    output a_addr_t      o_a_addr,
    input  wire word_t   i_a_word,
    output b_addr_t      o_b_addr,
    input  wire word_t   i_b_word,
    input  wire logic    i_e_wen,
    input  wire c_idx_t  i_e_idx,
    input  wire elem_t   i_e_data,
    input  wire logic    i_c_en,
    input  wire c_idx_t  i_c_idx,
    output elem_t        o_c
);

    step_if step ();

    elem_t  lane_sum;
    logic   lane_valid;
    logic   lane_first;
    logic   lane_last;
    c_idx_t lane_idx;
    elem_t  e_elem;

    mm_ctrl u_ctrl (
        .i_clk    (i_clk),
        .i_rst_n  (i_rst_n),
        .i_start  (i_start),
        .o_a_addr (o_a_addr),
        .o_b_addr (o_b_addr),
        .o_busy   (o_busy),
        .o_done   (o_done),
        .step     (step.seq)
    );

    dot_lanes u_lanes (
        .i_clk    (i_clk),
        .i_rst_n  (i_rst_n),
        .i_a_word (i_a_word),
        .i_b_word (i_b_word),
        .step     (step.sink),
        .o_sum    (lane_sum),
        .o_valid  (lane_valid),
        .o_first  (lane_first),
        .o_last   (lane_last),
        .o_idx    (lane_idx)
    );

    e_buffer u_ebuf (
        .i_clk    (i_clk),
        .i_e_wen  (i_e_wen),
        .i_e_idx  (i_e_idx),
        .i_e_data (i_e_data),
        .step     (step.sink),
        .o_e      (e_elem)
    );

    result_acc u_acc (
        .i_clk    (i_clk),
        .i_rst_n  (i_rst_n),
        .i_sum    (lane_sum),
        .i_valid  (lane_valid),
        .i_first  (lane_first),
        .i_last   (lane_last),
        .i_idx    (lane_idx),
        .i_e      (e_elem),
        .i_c_en   (i_c_en),
        .i_c_idx  (i_c_idx),
        .o_c      (o_c)
    );

endmodule

`default_nettype wire

/* src/result_acc.sv */
// combiner: accumulates lane sums, adds E and holds the C results for readout
`timescale 1ns/1ns
`default_nettype none

module result_acc
    import matmul_pkg::*;
(
    input  wire logic   i_clk,
    input  wire logic   i_rst_n,
    input  wire elem_t  i_sum,
    input  wire logic   i_valid,
    input  wire logic   i_first,
    input  wire logic   i_last,
    input  wire c_idx_t i_idx,
    input  wire elem_t  i_e,
    input  wire logic   i_c_en,
    input  wire c_idx_t i_c_idx,
    output elem_t       o_c
);

    elem_t acc_q;
    elem_t acc_next;
    elem_t c_mem [C_ELEMS];
    logic  wr_en;

    // first word starts a fresh dot product
    assign acc_next = i_first ? i_sum : acc_q + i_sum;
    assign wr_en    = i_valid && i_last;

    always_ff @(posedge i_clk) begin
        if (i_valid) begin
            acc_q <= acc_next;
        end
    end

    // ====================
    // C memory
    // ====================
    always_ff @(posedge i_clk) begin
        if (wr_en) begin
            c_mem[i_idx] <= acc_next + i_e;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_c_en) begin
            o_c <= c_mem[i_c_idx];
        end
    end

    // readout only between runs
    a_no_read_on_write: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        !(i_c_en && wr_en));

endmodule

`default_nettype wire

/* src/e_buffer.sv */
// E element store, loaded from outside and read out in step with the lane sums
`timescale 1ns/1ns
`default_nettype none

module e_buffer
    import matmul_pkg::*;
(
    input  wire logic   i_clk,
    input  wire logic   i_e_wen,
    input  wire c_idx_t i_e_idx,
    input  wire elem_t  i_e_data,
    step_if.sink        step,
    output elem_t       o_e
);

    elem_t e_mem [C_ELEMS];
    elem_t rd_q  [PIPE_DEPTH];

    always_ff @(posedge i_clk) begin
        if (i_e_wen) begin
            e_mem[i_e_idx] <= i_e_data;
        end
    end

    // read stage, then padding up to the lane latency
    always_ff @(posedge i_clk) begin
        rd_q[0] <= e_mem[step.idx];
        for (int k = 1; k < PIPE_DEPTH; k++) begin
            rd_q[k] <= rd_q[k-1];
        end
    end

    assign o_e = rd_q[PIPE_DEPTH-1];

    a_no_load_in_run: assert property (@(posedge i_clk)
        i_e_wen |-> !step.valid);

endmodule

`default_nettype wire

/* src/dot_lanes.sv */
// multiplier lanes with a registered adder tree, one partial dot sum per step tag
`timescale 1ns/1ns
`default_nettype none

`include "matmul_cfg.svh"

module dot_lanes
    import matmul_pkg::*;
(
    input  wire logic  i_clk,
    input  wire logic  i_rst_n,
    input  wire word_t i_a_word,
    input  wire word_t i_b_word,
    step_if.sink       step,
    output elem_t      o_sum,
    output logic       o_valid,
    output logic       o_first,
    output logic       o_last,
    output c_idx_t     o_idx
);

    word_t                 a_q;
    word_t                 b_q;
    word_t                 prod_q;
    // heap order, node 0 is the root
    elem_t                 node [2*`MM_LANES-1];
    logic [PIPE_DEPTH-1:0] vld_q;
    logic [PIPE_DEPTH-1:0] first_q;
    logic [PIPE_DEPTH-1:0] last_q;
    c_idx_t                idx_q [PIPE_DEPTH];

    // operands, products, sum
    always_ff @(posedge i_clk) begin
        a_q <= i_a_word;
        b_q <= i_b_word;
        for (int l = 0; l < `MM_LANES; l++) begin
            prod_q[l] <= a_q[l] * b_q[l];
        end
        o_sum <= node[0];
    end

    for (genvar l = 0; l < `MM_LANES; l++) begin : g_leaf
        assign node[`MM_LANES-1+l] = prod_q[l];
    end

    for (genvar n = 0; n < `MM_LANES-1; n++) begin : g_node
        assign node[n] = node[2*n+1] + node[2*n+2];
    end

    // tag delay line, matches the three data stages
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            vld_q <= '0;
        end else begin
            vld_q <= {vld_q[PIPE_DEPTH-2:0], step.valid};
        end
    end

    always_ff @(posedge i_clk) begin
        first_q  <= {first_q[PIPE_DEPTH-2:0], step.first};
        last_q   <= {last_q[PIPE_DEPTH-2:0], step.last};
        idx_q[0] <= step.idx;
        for (int k = 1; k < PIPE_DEPTH; k++) begin
            idx_q[k] <= idx_q[k-1];
        end
    end

    assign o_valid = vld_q[PIPE_DEPTH-1];
    assign o_first = first_q[PIPE_DEPTH-1];
    assign o_last  = last_q[PIPE_DEPTH-1];
    assign o_idx   = idx_q[PIPE_DEPTH-1];

endmodule

`default_nettype wire

/* src/mm_ctrl.sv */
// run sequencer: walks all C elements, issues operand fetches and step tags, flags busy and done
`timescale 1ns/1ns
`default_nettype none

`include "matmul_cfg.svh"

module mm_ctrl
    import matmul_pkg::*;
(
    input  wire logic i_clk,
    input  wire logic i_rst_n,
    input  wire logic i_start,
    output a_addr_t   o_a_addr,
    output b_addr_t   o_b_addr,
    output logic      o_busy,
    output logic      o_done,
    step_if.seq       step
);

    localparam int ROW_W = $clog2(`MM_A_ROWS);
    localparam int COL_W = $clog2(`MM_B_COLS);
    localparam int WRD_W = $clog2(WORDS_PER_DOT);
    // done rises with the last C write
    localparam int DRAIN_LAST = PIPE_DEPTH + 1;
    localparam int DRN_W = $clog2(DRAIN_LAST + 1);

    ctrl_state_t      state;
    logic [ROW_W-1:0] row;
    logic [COL_W-1:0] col;
    logic [WRD_W-1:0] word;
    logic [DRN_W-1:0] drain_cnt;
    logic             issue;
    logic             final_step;
    logic             word_end;

    // tag of the word in flight from memory
    logic             pend_valid;
    logic             pend_first;
    logic             pend_last;
    c_idx_t           pend_idx;

    assign issue      = (state == IDLE && i_start) || state == RUN;
    assign word_end   = word == WRD_W'(WORDS_PER_DOT - 1);
    assign final_step = word_end && col == COL_W'(`MM_B_COLS - 1) &&
                        row == ROW_W'(`MM_A_ROWS - 1);

    // ====================
    // state machine
    // ====================
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            state     <= IDLE;
            o_busy    <= 1'b0;
            o_done    <= 1'b0;
            drain_cnt <= '0;
        end else begin
            o_done <= 1'b0;
            case (state)
                IDLE: begin
                    if (i_start) begin
                        state  <= RUN;
                        o_busy <= 1'b1;
                    end
                end
                RUN: begin
                    if (final_step) begin
                        state     <= DRAIN;
                        drain_cnt <= '0;
                    end
                end
                DRAIN: begin
                    if (drain_cnt == DRN_W'(DRAIN_LAST)) begin
                        state  <= DONE;
                        o_done <= 1'b1;
                        o_busy <= 1'b0;
                    end else begin
                        drain_cnt <= drain_cnt + 1'b1;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // ====================
    // walk and fetch
    // ====================
    // word fastest, then column, then row
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            row        <= '0;
            col        <= '0;
            word       <= '0;
            o_a_addr   <= '0;
            o_b_addr   <= '0;
            pend_valid <= 1'b0;
        end else begin
            pend_valid <= issue;
            if (issue) begin
                o_a_addr <= a_addr_t'(row * WORDS_PER_DOT + word);
                o_b_addr <= b_addr_t'(col * WORDS_PER_DOT + word);
                if (word_end) begin
                    word <= '0;
                    if (col == COL_W'(`MM_B_COLS - 1)) begin
                        col <= '0;
                        row <= (row == ROW_W'(`MM_A_ROWS - 1)) ? '0 : row + 1'b1;
                    end else begin
                        col <= col + 1'b1;
                    end
                end else begin
                    word <= word + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (issue) begin
            pend_first <= word == '0;
            pend_last  <= word_end;
            pend_idx   <= c_idx_t'(row * `MM_B_COLS + col);
        end
    end

    // tag goes out with the word it describes
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            step.valid <= 1'b0;
        end else begin
            step.valid <= pend_valid;
        end
    end

    always_ff @(posedge i_clk) begin
        step.first <= pend_first;
        step.last  <= pend_last;
        step.idx   <= pend_idx;
    end

    a_done_after_drain: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        $rose(o_done) |-> $past(state) == DRAIN && $past(drain_cnt) == DRN_W'(DRAIN_LAST));

    a_no_tag_idle: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        state == IDLE |-> !step.valid);

endmodule

`default_nettype wire

/* src/step_if.sv */
// step tag bus from the sequencer to the lane array and the E buffer
`timescale 1ns/1ns
`default_nettype none

interface step_if
    import matmul_pkg::*;
();

    // one step is one memory word of a dot product
    logic   valid;
    logic   first;
    logic   last;
    // output element, row-major
    c_idx_t idx;

    modport seq (
        output valid,
        output first,
        output last,
        output idx
    );

    modport sink (
        input valid,
        input first,
        input last,
        input idx
    );

endinterface

`default_nettype wire

/* src/matmul_pkg.sv */
// shared types and derived sizes of the matrix engine, imported by the RTL and the testbench
`default_nettype none

`include "matmul_cfg.svh"

package matmul_pkg;

    // ====================
    // data types
    // ====================
    typedef logic [`MM_ELEM_W-1:0] elem_t;

    // lane 0 sits in the low bits
    typedef elem_t [`MM_LANES-1:0] word_t;

    localparam int C_ELEMS = `MM_A_ROWS * `MM_B_COLS;

    typedef logic [$clog2(C_ELEMS)-1:0] c_idx_t;
    typedef logic [$clog2(`MM_A_ROWS * `MM_INNER / `MM_LANES)-1:0] a_addr_t;
    typedef logic [$clog2(`MM_INNER * `MM_B_COLS / `MM_LANES)-1:0] b_addr_t;

    // memory words per dot product
    localparam int WORDS_PER_DOT = `MM_INNER / `MM_LANES;

    // latency of the lanes and of the E buffer
    localparam int PIPE_DEPTH = 3;

    typedef enum logic [1:0] {IDLE, RUN, DRAIN, DONE} ctrl_state_t;

endpackage

`default_nettype wire

/* src/matmul_cfg.svh */
// size configuration of the matrix engine, include wherever the macros are needed
`ifndef MATMUL_CFG_SVH
`define MATMUL_CFG_SVH

// ====================
// element and word
// ====================

// element width, arithmetic is modulo 2^MM_ELEM_W
`define MM_ELEM_W 16

// elements per memory word, also the multiplier count
`define MM_LANES 4

// ====================
// matrix dimensions
// ====================

// C = A(MM_A_ROWS x MM_INNER) * B(MM_INNER x MM_B_COLS) + E
`define MM_A_ROWS 4
`define MM_INNER 8
`define MM_B_COLS 4

`endif
